// ==== source/isaPkg.sv ====
package isaPkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int WORD_BITS = 32;
	localparam int REG_BITS = 5;
	localparam int OPCODE_BITS = 6;
	localparam int FUNCT_BITS = 6;
	localparam int IMMEDIATE_BITS = 16;

	// Field positions inside an instruction word
	localparam int OPCODE_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int FUNCT_LSB = 0;
	localparam int IMMEDIATE_LSB = 0;

	// ------------------------------------------------------------------------
	// Basic types
	// ------------------------------------------------------------------------
	// Data word and byte address
	typedef logic [WORD_BITS-1:0] word_t;
	// Register number, 32 registers
	typedef logic [REG_BITS-1:0] regIndex_t;
	// Raw immediate before sign extension
	typedef logic [IMMEDIATE_BITS-1:0] immediate_t;

	// Major opcode, bits 31..26
	typedef enum logic [OPCODE_BITS-1:0]
	{
		opRType = 6'h00,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_e;

	// Function field of R-type, bits 5..0
	typedef enum logic [FUNCT_BITS-1:0]
	{
		functAdd = 6'h20,
		functSub = 6'h22,
		functAnd = 6'h24,
		functOr = 6'h25,
		functSlt = 6'h2a
	} funct_e;

endpackage

// ==== source/pipelinePkg.sv ====
package pipelinePkg;

	// ------------------------------------------------------------------------
	// Execute-stage selects
	// ------------------------------------------------------------------------
	typedef enum logic [2:0]
	{
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluSlt = 3'd4
	} aluOp_e;

	// Source of an execute operand
	typedef enum logic [1:0]
	{
		fromRegister = 2'd0,
		fromMemory = 2'd1,
		fromWriteback = 2'd2
	} forwardSel_e;

	// Decoded control, 9 bits
	typedef struct packed
	{
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic branch;
		// 1 picks the immediate, 0 the register
		logic aluSource;
		// 1 writes rd, 0 writes rt
		logic regDest;
		aluOp_e aluOp;
	} controlBundle_t;

	// ------------------------------------------------------------------------
	// Pipeline registers
	// ------------------------------------------------------------------------
	typedef struct packed
	{
		logic valid;
		isaPkg::word_t instr;
		isaPkg::word_t pcPlus4;
	} ifIdReg_t;

	typedef struct packed
	{
		logic valid;
		controlBundle_t control;
		isaPkg::word_t readData1;
		isaPkg::word_t readData2;
		isaPkg::word_t signImm;
		isaPkg::regIndex_t rs;
		isaPkg::regIndex_t rt;
		isaPkg::regIndex_t rd;
	} idExReg_t;

	typedef struct packed
	{
		logic valid;
		controlBundle_t control;
		isaPkg::word_t aluResult;
		isaPkg::word_t writeData;
		isaPkg::regIndex_t writeReg;
	} exMemReg_t;

	// Only the writeback part of the control survives here
	typedef struct packed
	{
		logic valid;
		logic regWrite;
		logic memToReg;
		isaPkg::word_t readData;
		isaPkg::word_t aluResult;
		isaPkg::regIndex_t writeReg;
	} memWbReg_t;

	// Data memory size
	localparam int DATA_DEPTH_WORDS = 256;
	localparam int DATA_INDEX_BITS = 8;

endpackage

// ==== source/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit
(
	input isaPkg::opcode_e opcode,
	input isaPkg::funct_e funct,
	output pipelinePkg::controlBundle_t control,
	output logic illegal
);
	import isaPkg::*;
	import pipelinePkg::*;

	always_comb
	begin
		// Default is a bundle that writes nothing
		control = '0;
		control.aluOp = aluAdd;
		illegal = 1'b0;
		case (opcode)
			opRType:
			begin
				control.regWrite = 1'b1;
				control.regDest = 1'b1;
				case (funct)
					functAdd: control.aluOp = aluAdd;
					functSub: control.aluOp = aluSub;
					functAnd: control.aluOp = aluAnd;
					functOr: control.aluOp = aluOr;
					functSlt: control.aluOp = aluSlt;
					default:
					begin
						// Unknown funct, drop the write again
						control.regWrite = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			opAddi:
			begin
				control.regWrite = 1'b1;
				control.aluSource = 1'b1;
			end
			opLw:
			begin
				// Address is rs plus offset, result into rt
				control.regWrite = 1'b1;
				control.memToReg = 1'b1;
				control.aluSource = 1'b1;
			end
			opSw:
			begin
				control.memWrite = 1'b1;
				control.aluSource = 1'b1;
			end
			opBeq:
			begin
				// Resolved in decode, the ALU op is only informative
				control.branch = 1'b1;
				control.aluOp = aluSub;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ns

module registerFile
(
	input logic clk,
	input logic reset,
	input isaPkg::regIndex_t readReg1,
	input isaPkg::regIndex_t readReg2,
	output isaPkg::word_t readData1,
	output isaPkg::word_t readData2,
	input logic writeEnable,
	input isaPkg::regIndex_t writeReg,
	input isaPkg::word_t writeData
);
	import isaPkg::*;

	word_t registers [2**REG_BITS];

	// Zero register, then same-cycle write bypass, then the array
	function automatic word_t readPort(input regIndex_t index);
		word_t value;
		if (index == '0)
			value = '0;
		else if (writeEnable && (writeReg == index))
			value = writeData;
		else
			value = registers[index];
		return value;
	endfunction

	always_comb
	begin
		readData1 = readPort(readReg1);
		readData2 = readPort(readReg2);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 2**REG_BITS; i++)
				registers[i] <= '0;
		end
		else if (writeEnable && (writeReg != '0))
			registers[writeReg] <= writeData;
	end

	// $0 never changes, whatever writeback sends
	assert property (@(posedge clk) disable iff (reset) registers[0] == '0);

endmodule

// ==== source/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit
(
	input pipelinePkg::aluOp_e operation,
	input isaPkg::word_t sourceA,
	input isaPkg::word_t sourceB,
	output isaPkg::word_t result,
	output logic zero
);
	import pipelinePkg::*;

	always_comb
	begin
		case (operation)
			aluAdd: result = sourceA + sourceB;
			aluSub: result = sourceA - sourceB;
			aluAnd: result = sourceA & sourceB;
			aluOr: result = sourceA | sourceB;
			aluSlt:
			begin
				// Signed compare, result is 0 or 1
				result = '0;
				result[0] = $signed(sourceA) < $signed(sourceB);
			end
			default: result = '0;
		endcase
	end

	// Equality flag for sub
	assign zero = (result == '0);

endmodule

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit
(
	input isaPkg::regIndex_t decodeRs,
	input isaPkg::regIndex_t decodeRt,
	input logic decodeBranch,
	input pipelinePkg::idExReg_t execute,
	input isaPkg::regIndex_t executeWriteReg,
	input pipelinePkg::exMemReg_t memory,
	input pipelinePkg::memWbReg_t writeback,
	output pipelinePkg::forwardSel_e forwardA,
	output pipelinePkg::forwardSel_e forwardB,
	output logic forwardDecodeA,
	output logic forwardDecodeB,
	output logic stall,
	output logic flushExecute
);
	import isaPkg::*;
	import pipelinePkg::*;

	logic executeWrites;
	logic executeLoads;
	logic memoryWrites;
	logic memoryLoads;
	logic loadUse;
	logic branchOnExecute;
	logic branchOnLoad;

	// Live writer whose nonzero destination matches the source
	function automatic logic hits(input logic writes, input regIndex_t dest,
		input regIndex_t source);
		return writes && (dest != '0) && (dest == source);
	endfunction

	// Memory stage wins over writeback, it is the younger result
	function automatic forwardSel_e forwardFor(input regIndex_t source,
		input exMemReg_t mem, input memWbReg_t wb);
		forwardSel_e select;
		select = fromRegister;
		if (hits(mem.valid && mem.control.regWrite, mem.writeReg, source))
			select = fromMemory;
		else if (hits(wb.valid && wb.regWrite, wb.writeReg, source))
			select = fromWriteback;
		return select;
	endfunction

	// --------------------------------------------------------------------
	// Forwarding
	// --------------------------------------------------------------------
	assign forwardA = forwardFor(execute.rs, memory, writeback);
	assign forwardB = forwardFor(execute.rt, memory, writeback);

	assign memoryWrites = memory.valid && memory.control.regWrite;
	// Branch compare takes ALU results from memory, writeback goes via the file
	assign forwardDecodeA = hits(memoryWrites, memory.writeReg, decodeRs);
	assign forwardDecodeB = hits(memoryWrites, memory.writeReg, decodeRt);

	// --------------------------------------------------------------------
	// Stalls
	// --------------------------------------------------------------------
	assign executeWrites = execute.valid && execute.control.regWrite;
	assign executeLoads = executeWrites && execute.control.memToReg;
	assign memoryLoads = memoryWrites && memory.control.memToReg;

	// Load in execute, consumer in decode
	assign loadUse = hits(executeLoads, executeWriteReg, decodeRs)
		|| hits(executeLoads, executeWriteReg, decodeRt);
	// Branch operand still being computed
	assign branchOnExecute = decodeBranch && (hits(executeWrites, executeWriteReg, decodeRs)
		|| hits(executeWrites, executeWriteReg, decodeRt));
	// Branch operand is a load not yet back from memory
	assign branchOnLoad = decodeBranch && (hits(memoryLoads, memory.writeReg, decodeRs)
		|| hits(memoryLoads, memory.writeReg, decodeRt));

	assign stall = loadUse || branchOnExecute || branchOnLoad;
	// Held instruction leaves a bubble behind it
	assign flushExecute = stall;

endmodule

// ==== source/dataMemory.sv ====
`timescale 1ns/1ns

module dataMemory
(
	input logic clk,
	input logic writeEnable,
	input isaPkg::word_t address,
	input isaPkg::word_t writeData,
	output isaPkg::word_t readData
);
	import isaPkg::*;
	import pipelinePkg::*;

	// Starts out all zero
	word_t words [DATA_DEPTH_WORDS] = '{default: '0};
	logic [DATA_INDEX_BITS-1:0] index;

	// Word index sits above the byte offset
	assign index = address[DATA_INDEX_BITS+1:2];

	// Load data is ready in the same cycle
	assign readData = words[index];

	always_ff @(posedge clk)
	begin
		if (writeEnable)
			words[index] <= writeData;
	end

	// Stores are whole words
	assert property (@(posedge clk) writeEnable |-> address[1:0] == 2'b00);

endmodule

// ==== source/mipsPipeline.sv ====
`timescale 1ns/1ns

module mipsPipeline
(
	input logic clk,
	input logic reset,
	output isaPkg::word_t instrAddress,
	input isaPkg::word_t instr,
	output logic retireValid,
	output isaPkg::regIndex_t retireReg,
	output isaPkg::word_t retireData
);
	import isaPkg::*;
	import pipelinePkg::*;

	// Fetch
	word_t pc;
	word_t pcPlus4;
	ifIdReg_t ifId;
	// Decode
	controlBundle_t decodeControl;
	logic illegal;
	regIndex_t decodeRs;
	regIndex_t decodeRt;
	immediate_t immediate;
	word_t signImm;
	word_t regData1;
	word_t regData2;
	word_t compareA;
	word_t compareB;
	word_t branchTarget;
	logic decodeBranch;
	logic branchTaken;
	idExReg_t idEx;
	// Execute
	word_t aluSourceA;
	word_t storeData;
	word_t aluSourceB;
	word_t aluResult;
	logic aluZero;
	regIndex_t executeWriteReg;
	exMemReg_t exMem;
	// Memory and writeback
	word_t memReadData;
	memWbReg_t memWb;
	word_t writebackResult;
	logic regWriteEnable;
	// Hazards
	forwardSel_e forwardA;
	forwardSel_e forwardB;
	logic forwardDecodeA;
	logic forwardDecodeB;
	logic stall;
	logic flushExecute;

	// ------------------------------------------------------------------------
	// Fetch
	// ------------------------------------------------------------------------
	assign instrAddress = pc;
	assign pcPlus4 = pc + 4;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
			ifId.valid <= 1'b0;
		end
		else if (!stall)
		begin
			pc <= branchTaken ? branchTarget : pcPlus4;
			// Taken branch kills the word fetched behind it
			ifId.valid <= !branchTaken;
			ifId.instr <= instr;
			ifId.pcPlus4 <= pcPlus4;
		end
	end

	// ------------------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------------------
	assign decodeRs = ifId.instr[RS_LSB +: REG_BITS];
	assign decodeRt = ifId.instr[RT_LSB +: REG_BITS];
	assign immediate = ifId.instr[IMMEDIATE_LSB +: IMMEDIATE_BITS];
	assign signImm = {{(WORD_BITS-IMMEDIATE_BITS){immediate[IMMEDIATE_BITS-1]}}, immediate};

	controlUnit control
	(
		.opcode(opcode_e'(ifId.instr[OPCODE_LSB +: OPCODE_BITS])),
		.funct(funct_e'(ifId.instr[FUNCT_LSB +: FUNCT_BITS])),
		.control(decodeControl),
		.illegal(illegal)
	);

	registerFile registers
	(
		.clk(clk),
		.reset(reset),
		.readReg1(decodeRs),
		.readReg2(decodeRt),
		.readData1(regData1),
		.readData2(regData2),
		.writeEnable(regWriteEnable),
		.writeReg(memWb.writeReg),
		.writeData(writebackResult)
	);

	// Branch compare, ALU result in memory overrides the file
	assign compareA = forwardDecodeA ? exMem.aluResult : regData1;
	assign compareB = forwardDecodeB ? exMem.aluResult : regData2;
	assign branchTarget = ifId.pcPlus4 + {signImm[WORD_BITS-3:0], 2'b00};
	assign decodeBranch = ifId.valid && decodeControl.branch;
	// No redirect while the operands are still in flight
	assign branchTaken = decodeBranch && (compareA == compareB) && !stall;

	always_ff @(posedge clk)
	begin
		if (reset || flushExecute)
			idEx.valid <= 1'b0;
		else
		begin
			idEx.valid <= ifId.valid;
			idEx.control <= decodeControl;
			idEx.readData1 <= regData1;
			idEx.readData2 <= regData2;
			idEx.signImm <= signImm;
			idEx.rs <= decodeRs;
			idEx.rt <= decodeRt;
			idEx.rd <= ifId.instr[RD_LSB +: REG_BITS];
		end
	end

	// ------------------------------------------------------------------------
	// Execute
	// ------------------------------------------------------------------------
	always_comb
	begin
		case (forwardA)
			fromMemory: aluSourceA = exMem.aluResult;
			fromWriteback: aluSourceA = writebackResult;
			default: aluSourceA = idEx.readData1;
		endcase
		case (forwardB)
			fromMemory: storeData = exMem.aluResult;
			fromWriteback: storeData = writebackResult;
			default: storeData = idEx.readData2;
		endcase
	end

	assign aluSourceB = idEx.control.aluSource ? idEx.signImm : storeData;
	assign executeWriteReg = idEx.control.regDest ? idEx.rd : idEx.rt;

	aluUnit alu
	(
		.operation(idEx.control.aluOp),
		.sourceA(aluSourceA),
		.sourceB(aluSourceB),
		.result(aluResult),
		.zero(aluZero)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			exMem.valid <= 1'b0;
		else
		begin
			exMem.valid <= idEx.valid;
			exMem.control <= idEx.control;
			exMem.aluResult <= aluResult;
			exMem.writeData <= storeData;
			exMem.writeReg <= executeWriteReg;
		end
	end

	// ------------------------------------------------------------------------
	// Memory
	// ------------------------------------------------------------------------
	dataMemory memory
	(
		.clk(clk),
		.writeEnable(exMem.valid && exMem.control.memWrite),
		.address(exMem.aluResult),
		.writeData(exMem.writeData),
		.readData(memReadData)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
			memWb.valid <= 1'b0;
		else
		begin
			memWb.valid <= exMem.valid;
			memWb.regWrite <= exMem.control.regWrite;
			memWb.memToReg <= exMem.control.memToReg;
			memWb.readData <= memReadData;
			memWb.aluResult <= exMem.aluResult;
			memWb.writeReg <= exMem.writeReg;
		end
	end

	// ------------------------------------------------------------------------
	// Writeback and retire
	// ------------------------------------------------------------------------
	assign writebackResult = memWb.memToReg ? memWb.readData : memWb.aluResult;
	assign regWriteEnable = memWb.valid && memWb.regWrite;
	// Writes to $0 are not reported
	assign retireValid = regWriteEnable && (memWb.writeReg != '0);
	assign retireReg = memWb.writeReg;
	assign retireData = writebackResult;

	// ------------------------------------------------------------------------
	// Hazards
	// ------------------------------------------------------------------------
	hazardUnit hazards
	(
		.decodeRs(decodeRs),
		.decodeRt(decodeRt),
		.decodeBranch(decodeBranch),
		.execute(idEx),
		.executeWriteReg(executeWriteReg),
		.memory(exMem),
		.writeback(memWb),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.forwardDecodeA(forwardDecodeA),
		.forwardDecodeB(forwardDecodeB),
		.stall(stall),
		.flushExecute(flushExecute)
	);

	// Only known encodings reach a live decode slot
	assert property (@(posedge clk) disable iff (reset) ifId.valid |-> !illegal);

	// Memory forwarding needs a live stage and never hands a load address to a live operand
	assert property (@(posedge clk) disable iff (reset)
		forwardA == fromMemory |-> exMem.valid && !(idEx.valid && exMem.control.memToReg));

	// Second stall in a row only for a branch waiting on a load in memory
	assert property (@(posedge clk) disable iff (reset)
		stall && $past(stall) |-> decodeBranch && exMem.valid && exMem.control.memToReg);

	// Sub of a beq in execute agrees with the decode compare that steered fetch
	assert property (@(posedge clk) disable iff (reset)
		idEx.valid && idEx.control.branch |-> aluZero == $past(branchTaken));

endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/1ns

module clockGen
(
	output logic clk,
	output logic reset
);
	// 20 ns period
	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 3;

	initial
	begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// Reset held for three rising edges, released on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== verification/mipsPipelineTb.sv ====
`timescale 1ns/1ns

module mipsPipelineTb;
	import isaPkg::*;

	localparam int PROGRAM_WORDS = 40;
	localparam int HALT_HOLD_CYCLES = 10;
	localparam int MODEL_STEP_LIMIT = 2000;
	// add $0, $0, $0
	localparam word_t NOP_WORD = 32'h0000_0020;

	logic clk;
	logic reset;
	word_t instrAddress;
	word_t instr;
	logic retireValid;
	regIndex_t retireReg;
	word_t retireData;

	integer seed;
	word_t programImage [PROGRAM_WORDS];
	int programLength;
	word_t haltAddress = '1;
	// Expected writes in program order, nonzero destinations only
	regIndex_t expectRegs [$];
	word_t expectData [$];
	int modelSteps;
	int retiredCount = 0;
	int haltCycles = 0;
	logic resetSeen = 1'b0;

	clockGen clocks
	(
		.clk(clk),
		.reset(reset)
	);

	mipsPipeline dut
	(
		.clk(clk),
		.reset(reset),
		.instrAddress(instrAddress),
		.instr(instr),
		.retireValid(retireValid),
		.retireReg(retireReg),
		.retireData(retireData)
	);

	// Instruction memory, answers in the same cycle
	always_comb
	begin
		if (instrAddress < word_t'(PROGRAM_WORDS * 4))
			instr = programImage[instrAddress[7:2]];
		else
			instr = NOP_WORD;
	end

	// ------------------------------------------------------------------------
	// Encoding helpers
	// ------------------------------------------------------------------------
	function automatic word_t rFormat(input funct_e funct, input regIndex_t rd,
		input regIndex_t rs, input regIndex_t rt);
		return {opRType, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t iFormat(input opcode_e op, input regIndex_t rt,
		input regIndex_t rs, input immediate_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic immediate_t drawImmediate();
		word_t value;
		value = $random(seed);
		return value[15:0];
	endfunction

	task automatic emit(input word_t word);
		programImage[programLength] = word;
		programLength++;
	endtask

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic reportMismatch(input string name, input word_t expected,
		input word_t actual);
		failRun($sformatf("[FAIL] %0t ns: %s expected 0x%08h, got 0x%08h",
			$time, name, expected, actual));
	endtask

	// ------------------------------------------------------------------------
	// Program image
	// ------------------------------------------------------------------------
	task automatic assemble();
		immediate_t base;
		immediate_t offset1;
		immediate_t offset2;
		immediate_t offset3;
		// Aligned, well inside the data memory
		base = 16'h0100 | (drawImmediate() & 16'h00fc);
		// Three distinct slots
		offset1 = drawImmediate() & 16'h001c;
		offset2 = 16'h0020 | (drawImmediate() & 16'h001c);
		offset3 = 16'h0040 | (drawImmediate() & 16'h001c);
		for (int i = 0; i < PROGRAM_WORDS; i++)
			programImage[i] = NOP_WORD;
		programLength = 0;
		// Constants, then a dependent ALU chain
		emit(iFormat(opAddi, 5'd1, 5'd0, drawImmediate()));
		emit(iFormat(opAddi, 5'd2, 5'd0, drawImmediate()));
		emit(rFormat(functAdd, 5'd3, 5'd1, 5'd2));
		emit(rFormat(functSub, 5'd4, 5'd3, 5'd1));
		emit(rFormat(functAnd, 5'd5, 5'd4, 5'd3));
		emit(rFormat(functOr, 5'd6, 5'd5, 5'd4));
		emit(rFormat(functSlt, 5'd7, 5'd6, 5'd5));
		emit(iFormat(opAddi, 5'd8, 5'd7, drawImmediate()));
		emit(rFormat(functSlt, 5'd9, 5'd2, 5'd1));
		// Store then load, load-use, load feeding a store
		emit(iFormat(opAddi, 5'd10, 5'd0, base));
		emit(iFormat(opSw, 5'd3, 5'd10, offset1));
		emit(iFormat(opLw, 5'd11, 5'd10, offset1));
		emit(rFormat(functAdd, 5'd12, 5'd11, 5'd1));
		emit(iFormat(opSw, 5'd12, 5'd10, offset2));
		emit(iFormat(opLw, 5'd13, 5'd10, offset2));
		emit(iFormat(opSw, 5'd13, 5'd10, offset3));
		emit(iFormat(opLw, 5'd14, 5'd10, offset3));
		// Taken beq right behind a load, the addi after it is skipped
		emit(iFormat(opBeq, 5'd13, 5'd14, 16'd1));
		emit(iFormat(opAddi, 5'd15, 5'd0, 16'd1));
		// Not taken, operand from the addi just ahead
		emit(iFormat(opAddi, 5'd16, 5'd0, drawImmediate() | 16'h0001));
		emit(iFormat(opBeq, 5'd0, 5'd16, 16'd1));
		emit(iFormat(opAddi, 5'd17, 5'd16, drawImmediate()));
		// $0 as destination, then as a source
		emit(iFormat(opAddi, 5'd0, 5'd0, drawImmediate()));
		emit(rFormat(functAdd, 5'd18, 5'd0, 5'd17));
		// Counted loop, 2 to 5 passes
		emit(iFormat(opAddi, 5'd19, 5'd0, 16'd2 + (drawImmediate() & 16'h0003)));
		emit(iFormat(opAddi, 5'd20, 5'd0, 16'd0));
		emit(rFormat(functAdd, 5'd20, 5'd20, 5'd1));
		emit(iFormat(opAddi, 5'd19, 5'd19, 16'hffff));
		emit(iFormat(opBeq, 5'd0, 5'd19, 16'd1));
		// Back by four words
		emit(iFormat(opBeq, 5'd0, 5'd0, 16'hfffc));
		emit(rFormat(functAdd, 5'd21, 5'd20, 5'd18));
		// Branch waiting on a load in memory
		emit(iFormat(opLw, 5'd22, 5'd10, offset1));
		emit(iFormat(opBeq, 5'd3, 5'd22, 16'd1));
		emit(iFormat(opAddi, 5'd23, 5'd0, 16'd7));
		emit(iFormat(opAddi, 5'd0, 5'd22, 16'd5));
		emit(rFormat(functOr, 5'd24, 5'd0, 5'd22));
		// Halt, beq $0, $0 onto itself
		haltAddress = word_t'(programLength * 4);
		emit(iFormat(opBeq, 5'd0, 5'd0, 16'hffff));
	endtask

	// ------------------------------------------------------------------------
	// Reference model, one instruction per step in program order
	// ------------------------------------------------------------------------
	task automatic referenceRun();
		word_t regs [32];
		word_t memoryWords [word_t];
		word_t pc;
		word_t word;
		word_t a;
		word_t b;
		word_t imm;
		word_t value;
		regIndex_t dest;
		logic writes;
		pc = '0;
		modelSteps = 0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		while (pc != haltAddress && modelSteps < MODEL_STEP_LIMIT)
		begin
			word = programImage[pc[7:2]];
			a = regs[word[25:21]];
			b = regs[word[20:16]];
			imm = {{16{word[15]}}, word[15:0]};
			writes = 1'b0;
			dest = word[20:16];
			value = '0;
			pc = pc + 32'd4;
			case (word[31:26])
				opRType:
				begin
					writes = 1'b1;
					dest = word[15:11];
					case (word[5:0])
						functAdd: value = a + b;
						functSub: value = a - b;
						functAnd: value = a & b;
						functOr: value = a | b;
						functSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				opAddi:
				begin
					writes = 1'b1;
					value = a + imm;
				end
				opLw:
				begin
					// Untouched words read as zero
					writes = 1'b1;
					value = memoryWords.exists(a + imm) ? memoryWords[a + imm] : '0;
				end
				opSw: memoryWords[a + imm] = b;
				// Target relative to the next word, no delay slot
				opBeq:
				begin
					if (a == b)
						pc = pc + (imm << 2);
				end
				default: writes = 1'b0;
			endcase
			if (writes && dest != '0)
			begin
				regs[dest] = value;
				expectRegs.push_back(dest);
				expectData.push_back(value);
			end
			modelSteps++;
		end
	endtask

	// Build, predict, then watchdog
	initial
	begin
		seed = 32'h8a91;
		assemble();
		referenceRun();
		// Three cycles per step covers every stall and flush
		repeat (modelSteps * 3 + 50) @(posedge clk);
		failRun("Watchdog expired: the program did not reach the halt loop");
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		// During reset and the cycle right after it
		if (resetSeen)
		begin
			assert (retireValid == 1'b0)
			else reportMismatch("retireValid", '0, word_t'(retireValid));
			assert (instrAddress == '0)
			else reportMismatch("instrAddress", '0, instrAddress);
		end
		resetSeen = reset;

		// Each retired write against the head of the model's list
		if (!reset && retireValid)
		begin
			assert (retiredCount < expectRegs.size())
			else failRun("A register write retired that the reference model does not expect");
			assert (retireReg == expectRegs[retiredCount])
			else reportMismatch("retireReg", word_t'(expectRegs[retiredCount]),
				word_t'(retireReg));
			assert (retireData == expectData[retiredCount])
			else reportMismatch("retireData", expectData[retiredCount], retireData);
			retiredCount++;
		end

		// Halt loop bounces between the beq and the word after it
		if (!reset && (instrAddress == haltAddress || instrAddress == haltAddress + 32'd4))
			haltCycles++;
		else
			haltCycles = 0;

		if (haltCycles == HALT_HOLD_CYCLES)
		begin
			if (retiredCount == expectRegs.size())
			begin
				$display("=== PASS ===");
				$finish;
			end
			else
				failRun($sformatf("Halt reached with %0d expected register writes never retired",
					expectRegs.size() - retiredCount));
		end
	end

endmodule

// ==== verilog.f ====
source/isaPkg.sv
source/pipelinePkg.sv
source/controlUnit.sv
source/registerFile.sv
source/aluUnit.sv
source/hazardUnit.sv
source/dataMemory.sv
source/mipsPipeline.sv
verification/clockGen.sv
verification/mipsPipelineTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mipsPipelineTb
FILELIST = verilog.f
BUILDDIR = obj_dir

BINARY  = $(BUILDDIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BINARY)

# Rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILDDIR)
